// ==== Makefile ====
SRCS := $(shell cat sources.f)

.PHONY: run clean

run: obj_dir/Vtb_bp_predictor
	@out="$$(./obj_dir/Vtb_bp_predictor)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

obj_dir/Vtb_bp_predictor: sources.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_bp_predictor -f sources.f

clean:
	rm -rf obj_dir

// ==== hdl/bp_pkg.sv ====
// Return address predictor package

package bp_pkg;

  // --------------------
  // sizes
  // --------------------

  // virtual address width
  localparam int VADDR_W = 32;

  // bytes per fetch block, two bytes per slot
  localparam int FETCH_BYTES = 8;

  // return stack entries
  localparam int RAS_DEPTH = 8;
  localparam int RAS_IDX_W = $clog2(RAS_DEPTH);

  typedef logic [VADDR_W-1:0]   vaddr_t;
  typedef logic [RAS_IDX_W-1:0] ras_idx_t;

  // --------------------
  // encodings
  // --------------------

  // kind of control flow found in a block
  typedef enum logic [1:0] {
    CF_NONE = 2'd0,
    CF_CALL = 2'd1,
    CF_RET  = 2'd2,
    CF_JUMP = 2'd3
  } cf_kind_t;

  // major opcodes of the 32-bit jumps
  typedef enum logic [6:0] {
    OPC_JALR = 7'b1100111,
    OPC_JAL  = 7'b1101111
  } opcode_t;

  // --------------------
  // bundles
  // --------------------

  // one fetch block from the instruction cache
  typedef struct packed {
    logic                       valid;
    vaddr_t                     vaddr;  // block aligned
    logic [FETCH_BYTES*8-1:0]   data;
    logic [FETCH_BYTES-1:0]     be;
  } fetch_blk_t;

  // branch resolution from the back end
  typedef struct packed {
    logic     update;
    logic     dead;
    logic     mispredict;
    logic     is_call;
    logic     is_ret;
    ras_idx_t ras_index;
    vaddr_t   ret_vaddr;
  } br_upd_t;

  // first control-flow slot of a block
  typedef struct packed {
    cf_kind_t kind;
    logic     is_std;       // call with an immediate target (jal, c.jal)
    vaddr_t   call_target;
    vaddr_t   ret_vaddr;
  } decode_t;

  // return stack write request
  typedef struct packed {
    logic     valid;
    ras_idx_t index;
    vaddr_t   data;
  } ras_wr_t;

  // prediction towards fetch
  typedef struct packed {
    logic     valid;
    cf_kind_t kind;
    vaddr_t   target;
  } pred_t;

endpackage

// ==== hdl/bp_predecode.sv ====
// Fetch block predecode
`timescale 1ns/100ps

module bp_predecode #(
  parameter int FETCH_BYTES = bp_pkg::FETCH_BYTES
) (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  bp_pkg::fetch_blk_t i_fetch,
  output bp_pkg::decode_t    o_decode
);

  localparam int SLOTS  = FETCH_BYTES / 2;
  localparam int DATA_W = FETCH_BYTES * 8;

  // state carried over from the previous block
  logic           r_straddle;
  logic [15:0]    r_prev_upper;
  bp_pkg::vaddr_t r_next_blk;

  logic               w_consec;
  logic               w_tail_lo;
  logic [DATA_W+15:0] w_data_ext;

  // --------------------
  // decode helpers
  // --------------------

  function automatic bp_pkg::vaddr_t f_j_imm(input logic [31:0] inst);
    return {{(bp_pkg::VADDR_W-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  endfunction

  function automatic bp_pkg::vaddr_t f_cj_imm(input logic [15:0] c);
    return {{(bp_pkg::VADDR_W-11){c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11],
            c[5:3], 1'b0};
  endfunction

  function automatic bp_pkg::cf_kind_t f_dec32(input logic [31:0] inst);
    bp_pkg::cf_kind_t kind;
    kind = bp_pkg::CF_NONE;
    if (inst[6:0] == bp_pkg::OPC_JAL) begin
      kind = (inst[11:7] == 5'd1) ? bp_pkg::CF_CALL : bp_pkg::CF_JUMP;
    end else if (inst[6:0] == bp_pkg::OPC_JALR && inst[14:12] == 3'b000) begin
      // jalr x0, x1, 0
      if (inst[11:7] == 5'd0 && inst[19:15] == 5'd1 && inst[31:20] == 12'h000) begin
        kind = bp_pkg::CF_RET;
      end else if (inst[11:7] == 5'd1) begin
        kind = bp_pkg::CF_CALL;
      end else begin
        kind = bp_pkg::CF_JUMP;
      end
    end
    return kind;
  endfunction

  function automatic bp_pkg::cf_kind_t f_dec16(input logic [15:0] c);
    bp_pkg::cf_kind_t kind;
    kind = bp_pkg::CF_NONE;
    if (c[1:0] == 2'b01 && c[15:13] == 3'b001) begin
      kind = bp_pkg::CF_CALL;  // c.jal, rv32 only
    end else if (c[1:0] == 2'b01 && c[15:13] == 3'b101) begin
      kind = bp_pkg::CF_JUMP;  // c.j
    end else if (c[1:0] == 2'b10 && c[6:2] == 5'd0 && c[11:7] != 5'd0) begin
      if (c[15:12] == 4'b1000) begin
        kind = (c[11:7] == 5'd1) ? bp_pkg::CF_RET : bp_pkg::CF_JUMP;
      end else if (c[15:12] == 4'b1001) begin
        kind = bp_pkg::CF_JUMP;  // c.jalr
      end
    end
    return kind;
  endfunction

  // --------------------
  // slot walk
  // --------------------

  // padding lets every slot take a 32-bit window
  assign w_data_ext = {16'h0000, i_fetch.data};
  assign w_consec   = r_straddle & (i_fetch.vaddr == r_next_blk);

  always_comb begin
    logic             hi;
    logic             lo;
    logic             std;
    logic             found;
    logic [31:0]      inst;
    logic [15:0]      c;
    bp_pkg::vaddr_t   pc;
    bp_pkg::cf_kind_t kind;

    o_decode      = '0;
    o_decode.kind = bp_pkg::CF_NONE;
    found         = 1'b0;
    hi            = 1'b0;
    for (int s = 0; s < SLOTS; s++) begin
      c    = w_data_ext[s*16 +: 16];
      inst = w_data_ext[s*16 +: 32];
      pc   = i_fetch.vaddr + bp_pkg::vaddr_t'(2 * s);
      kind = bp_pkg::CF_NONE;
      std  = 1'b0;
      lo   = 1'b0;
      if (s == 0 && w_consec) begin
        // upper half of an instruction begun in the previous block
        inst = {c, r_prev_upper};
        pc   = i_fetch.vaddr - bp_pkg::vaddr_t'(2);
        std  = 1'b1;
        kind = f_dec32(inst);
      end else if (!hi) begin
        if (c[1:0] == 2'b11) begin
          lo = 1'b1;
          // a start in the last slot finishes in the next block
          if (s < SLOTS - 1) begin
            std  = 1'b1;
            kind = f_dec32(inst);
          end
        end else begin
          kind = f_dec16(c);
        end
      end
      if (!found && kind != bp_pkg::CF_NONE && i_fetch.valid && i_fetch.be[2*s]) begin
        found                = 1'b1;
        o_decode.kind        = kind;
        o_decode.is_std      = (kind == bp_pkg::CF_CALL) &
                               (std ? (inst[6:0] == bp_pkg::OPC_JAL) : 1'b1);
        o_decode.call_target = pc + (std ? f_j_imm(inst) : f_cj_imm(c));
        o_decode.ret_vaddr   = pc + (std ? bp_pkg::vaddr_t'(4) : bp_pkg::vaddr_t'(2));
      end
      hi = lo;
    end
    w_tail_lo = hi;
  end

  // --------------------
  // straddle tracking
  // --------------------

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_straddle <= 1'b0;
    end else if (i_fetch.valid) begin
      r_straddle <= w_tail_lo;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fetch.valid) begin
      r_prev_upper <= i_fetch.data[DATA_W-1 -: 16];
      r_next_blk   <= i_fetch.vaddr + bp_pkg::vaddr_t'(FETCH_BYTES);
    end
  end

endmodule

// ==== hdl/bp_predictor.sv ====
// Return address predictor top
`timescale 1ns/100ps

module bp_predictor #(
  parameter int FETCH_BYTES = bp_pkg::FETCH_BYTES,
  parameter int RAS_DEPTH   = bp_pkg::RAS_DEPTH
) (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  bp_pkg::fetch_blk_t i_fetch,
  input  bp_pkg::br_upd_t    i_br_upd,
  output bp_pkg::pred_t      o_pred
);

  bp_pkg::decode_t  w_decode;
  bp_pkg::ras_idx_t w_rd_index;
  bp_pkg::vaddr_t   w_rd_data;
  bp_pkg::ras_wr_t  w_push;
  bp_pkg::ras_wr_t  w_repair;
  bp_pkg::ras_wr_t  w_wr;

  bp_predecode #(
    .FETCH_BYTES (FETCH_BYTES)
  ) u_predecode (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_fetch   (i_fetch),
    .o_decode  (w_decode)
  );

  bp_ras_ctrl #(
    .RAS_DEPTH (RAS_DEPTH)
  ) u_ras_ctrl (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_decode   (w_decode),
    .i_br_upd   (i_br_upd),
    .i_rd_data  (w_rd_data),
    .o_rd_index (w_rd_index),
    .o_push     (w_push),
    .o_repair   (w_repair),
    .o_pred     (o_pred)
  );

  bp_ras_arbiter u_ras_arbiter (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_push    (w_push),
    .i_repair  (w_repair),
    .o_wr      (w_wr)
  );

  bp_ras_mem #(
    .RAS_DEPTH (RAS_DEPTH)
  ) u_ras_mem (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_wr       (w_wr),
    .i_rd_index (w_rd_index),
    .o_rd_data  (w_rd_data)
  );

endmodule

// ==== hdl/bp_ras_arbiter.sv ====
// Return stack write arbiter
`timescale 1ns/100ps

module bp_ras_arbiter (
  input  logic            i_clk,
  input  logic            i_reset_n,
  input  bp_pkg::ras_wr_t i_push,
  input  bp_pkg::ras_wr_t i_repair,
  output bp_pkg::ras_wr_t o_wr
);

  // waiting repair
  bp_pkg::ras_wr_t r_hold;

  // fetch push always wins the port
  always_comb begin
    if (i_push.valid) begin
      o_wr = i_push;
    end else begin
      o_wr = r_hold;
    end
  end

  // --------------------
  // holding slot
  // --------------------

  // a new repair takes the slot, even over one still waiting
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_hold <= '0;
    end else if (i_repair.valid) begin
      r_hold <= i_repair;
    end else if (!i_push.valid) begin
      // held entry went out this cycle
      r_hold.valid <= 1'b0;
    end
  end

endmodule

// ==== hdl/bp_ras_ctrl.sv ====
// Return stack control
`timescale 1ns/100ps

module bp_ras_ctrl #(
  parameter int RAS_DEPTH = bp_pkg::RAS_DEPTH
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  bp_pkg::decode_t  i_decode,
  input  bp_pkg::br_upd_t  i_br_upd,
  input  bp_pkg::vaddr_t   i_rd_data,
  output bp_pkg::ras_idx_t o_rd_index,
  output bp_pkg::ras_wr_t  o_push,
  output bp_pkg::ras_wr_t  o_repair,
  output bp_pkg::pred_t    o_pred
);

  bp_pkg::ras_idx_t r_index;
  logic             r_recover;
  bp_pkg::pred_t    r_pred;

  logic             w_flush;
  logic             w_call;
  logic             w_ret;
  logic             w_call_dead;
  logic             w_ret_dead;
  bp_pkg::ras_idx_t w_base;
  bp_pkg::ras_idx_t w_index_next;

  // index wraps at the stack depth
  function automatic bp_pkg::ras_idx_t f_inc(input bp_pkg::ras_idx_t idx);
    return (idx == bp_pkg::ras_idx_t'(RAS_DEPTH - 1)) ? '0 : idx + 1'b1;
  endfunction

  function automatic bp_pkg::ras_idx_t f_dec(input bp_pkg::ras_idx_t idx);
    return (idx == '0) ? bp_pkg::ras_idx_t'(RAS_DEPTH - 1) : idx - 1'b1;
  endfunction

  // --------------------
  // stack index
  // --------------------

  assign w_flush = i_br_upd.update & ~i_br_upd.dead & i_br_upd.mispredict;
  assign w_base  = w_flush ? i_br_upd.ras_index : r_index;
  assign w_call  = (i_decode.kind == bp_pkg::CF_CALL);
  assign w_ret   = (i_decode.kind == bp_pkg::CF_RET);

  always_comb begin
    w_index_next = w_base;
    if (w_call) begin
      w_index_next = f_inc(w_base);
    end else if (w_ret) begin
      w_index_next = f_dec(w_base);
    end
  end

  assign o_rd_index = f_dec(w_base);
  assign o_push     = '{valid: w_call, index: w_base, data: i_decode.ret_vaddr};

  // --------------------
  // squashed call repair
  // --------------------

  assign w_call_dead = i_br_upd.update & i_br_upd.dead & i_br_upd.is_call;
  assign w_ret_dead  = i_br_upd.update & i_br_upd.dead & i_br_upd.is_ret;

  // only the first dead call of a squash restores its entry
  assign o_repair = '{valid: w_call_dead & ~r_recover,
                      index: i_br_upd.ras_index,
                      data:  i_br_upd.ret_vaddr};

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_index   <= '0;
      r_recover <= 1'b0;
    end else begin
      r_index <= w_index_next;
      if (w_call_dead | w_ret_dead) begin
        r_recover <= 1'b1;
      end else if (i_br_upd.update & ~i_br_upd.dead) begin
        r_recover <= 1'b0;
      end
    end
  end

  // --------------------
  // prediction
  // --------------------

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_pred <= '0;
    end else begin
      // jalr calls push but have no known target
      r_pred.valid  <= (w_call & i_decode.is_std) | w_ret;
      r_pred.kind   <= i_decode.kind;
      r_pred.target <= w_ret ? i_rd_data : i_decode.call_target;
    end
  end

  assign o_pred = r_pred;

endmodule

// ==== hdl/bp_ras_mem.sv ====
// Return address storage
`timescale 1ns/100ps

module bp_ras_mem #(
  parameter int RAS_DEPTH = bp_pkg::RAS_DEPTH
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  bp_pkg::ras_wr_t  i_wr,
  input  bp_pkg::ras_idx_t i_rd_index,
  output bp_pkg::vaddr_t   o_rd_data
);

  bp_pkg::vaddr_t r_entry [RAS_DEPTH];

  // single write port
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < RAS_DEPTH; i++) begin
        r_entry[i] <= '0;
      end
    end else if (i_wr.valid) begin
      r_entry[i_wr.index] <= i_wr.data;
    end
  end

  // read is combinational, same cycle as the pop
  assign o_rd_data = r_entry[i_rd_index];

endmodule

// ==== sources.f ====
hdl/bp_pkg.sv
hdl/bp_predecode.sv
hdl/bp_ras_ctrl.sv
hdl/bp_ras_arbiter.sv
hdl/bp_ras_mem.sv
hdl/bp_predictor.sv
tests/tb_bp_predictor.sv

// ==== tests/tb_bp_predictor.sv ====
// Return address predictor testbench
`timescale 1ns/100ps

module tb_bp_predictor;

  localparam int FETCH_BYTES = bp_pkg::FETCH_BYTES;
  localparam int RAS_DEPTH   = bp_pkg::RAS_DEPTH;
  localparam int DATA_W      = FETCH_BYTES * 8;
  localparam int SLOTS       = FETCH_BYTES / 2;
  localparam int CLK_PERIOD  = 4;
  localparam int NUM_TESTS   = 6;
  localparam logic [31:0] SEED = 32'he71e_9b4d;

  localparam logic [15:0] C_NOP   = 16'h0001;
  localparam logic [15:0] C_JR_RA = 16'h8082;       // c.jr x1
  localparam logic [31:0] RET_32  = 32'h0000_8067;  // jalr x0, x1, 0

  logic               clk = 1'b0;
  logic               reset_n;
  bp_pkg::fetch_blk_t fetch;
  bp_pkg::br_upd_t    br_upd;
  bp_pkg::pred_t      pred;

  int err_count;
  int check_count;

  // stack model
  bp_pkg::vaddr_t model_ras [RAS_DEPTH];
  int             model_idx;

  bp_predictor #(
    .FETCH_BYTES (FETCH_BYTES),
    .RAS_DEPTH   (RAS_DEPTH)
  ) u_bp_predictor (
    .i_clk     (clk),
    .i_reset_n (reset_n),
    .i_fetch   (fetch),
    .i_br_upd  (br_upd),
    .o_pred    (pred)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------
  // encodings
  // --------------------

  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // cj format with funct3 001 for c.jal and 101 for c.j
  function automatic logic [15:0] enc_cj(input logic [2:0] funct3, input logic [11:0] imm);
    return {funct3, imm[11], imm[4], imm[9:8], imm[10], imm[6], imm[7], imm[3:1],
            imm[5], 2'b01};
  endfunction

  function automatic bp_pkg::vaddr_t sext_j(input logic [20:0] imm);
    return {{(bp_pkg::VADDR_W-21){imm[20]}}, imm};
  endfunction

  function automatic bp_pkg::vaddr_t sext_c(input logic [11:0] imm);
    return {{(bp_pkg::VADDR_W-12){imm[11]}}, imm};
  endfunction

  function automatic logic [20:0] rand_j_imm();
    logic [31:0] r;
    r = $urandom;
    return {r[20:1], 1'b0};
  endfunction

  function automatic logic [11:0] rand_c_imm();
    logic [31:0] r;
    r = $urandom;
    return {r[11:1], 1'b0};
  endfunction

  function automatic bp_pkg::vaddr_t rand_addr();
    logic [31:0] r;
    r = $urandom;
    return r & ~bp_pkg::vaddr_t'(FETCH_BYTES - 1);
  endfunction

  function automatic logic [DATA_W-1:0] nop_block();
    logic [DATA_W-1:0] d;
    for (int s = 0; s < SLOTS; s++) begin
      d[s*16 +: 16] = C_NOP;
    end
    return d;
  endfunction

  function automatic bp_pkg::br_upd_t make_upd(input logic dead, input logic mispredict,
                                               input logic is_call, input int idx,
                                               input bp_pkg::vaddr_t ret_vaddr);
    bp_pkg::br_upd_t u;
    u            = '0;
    u.update     = 1'b1;
    u.dead       = dead;
    u.mispredict = mispredict;
    u.is_call    = is_call;
    u.ras_index  = bp_pkg::ras_idx_t'(idx);
    u.ret_vaddr  = ret_vaddr;
    return u;
  endfunction

  // --------------------
  // stack model
  // --------------------

  function automatic void model_push(input bp_pkg::vaddr_t ret_vaddr);
    model_ras[model_idx] = ret_vaddr;
    model_idx = (model_idx + 1) % RAS_DEPTH;
  endfunction

  function automatic bp_pkg::vaddr_t model_pop();
    model_idx = (model_idx + RAS_DEPTH - 1) % RAS_DEPTH;
    return model_ras[model_idx];
  endfunction

  // --------------------
  // drive and check
  // --------------------

  // one strobe cycle, then sample the registered prediction mid-cycle
  task automatic apply(input bp_pkg::fetch_blk_t blk, input bp_pkg::br_upd_t upd);
    @(posedge clk);
    fetch  <= blk;
    br_upd <= upd;
    @(posedge clk);
    fetch  <= '0;
    br_upd <= '0;
    @(negedge clk);
  endtask

  task automatic check_pred(input logic exp_valid, input bp_pkg::cf_kind_t exp_kind,
                            input bp_pkg::vaddr_t exp_target);
    check_count++;
    assert (pred.valid === exp_valid) else begin
      err_count++;
      $display("** Error at %0d ns: o_pred.valid = %0b, expected %0b",
               $time, pred.valid, exp_valid);
    end
    if (exp_valid) begin
      assert (pred.kind === exp_kind) else begin
        err_count++;
        $display("** Error at %0d ns: o_pred.kind = %0d, expected %0d",
                 $time, pred.kind, exp_kind);
      end
      assert (pred.target === exp_target) else begin
        err_count++;
        $display("** Error at %0d ns: o_pred.target = %h, expected %h",
                 $time, pred.target, exp_target);
      end
    end
  endtask

  task automatic fetch_expect(input bp_pkg::vaddr_t addr, input logic [DATA_W-1:0] data,
                              input logic [FETCH_BYTES-1:0] be, input logic exp_valid,
                              input bp_pkg::cf_kind_t exp_kind,
                              input bp_pkg::vaddr_t exp_target);
    bp_pkg::fetch_blk_t blk;
    blk = '{valid: 1'b1, vaddr: addr, data: data, be: be};
    apply(blk, '0);
    check_pred(exp_valid, exp_kind, exp_target);
  endtask

  task automatic call_jal(input bp_pkg::vaddr_t addr, input int slot);
    logic [DATA_W-1:0] d;
    logic [20:0]       imm;
    bp_pkg::vaddr_t    pc;
    imm = rand_j_imm();
    d   = nop_block();
    d[slot*16 +: 32] = enc_jal(5'd1, imm);
    pc  = addr + bp_pkg::vaddr_t'(2 * slot);
    model_push(pc + 4);
    fetch_expect(addr, d, '1, 1'b1, bp_pkg::CF_CALL, pc + sext_j(imm));
  endtask

  task automatic call_cjal(input bp_pkg::vaddr_t addr, input int slot);
    logic [DATA_W-1:0] d;
    logic [11:0]       imm;
    bp_pkg::vaddr_t    pc;
    imm = rand_c_imm();
    d   = nop_block();
    d[slot*16 +: 16] = enc_cj(3'b001, imm);
    pc  = addr + bp_pkg::vaddr_t'(2 * slot);
    // c.jal returns to the next half-word
    model_push(pc + 2);
    fetch_expect(addr, d, '1, 1'b1, bp_pkg::CF_CALL, pc + sext_c(imm));
  endtask

  task automatic send_ret(input bp_pkg::vaddr_t addr, input logic compressed);
    logic [DATA_W-1:0] d;
    d = nop_block();
    if (compressed) begin
      d[15:0] = C_JR_RA;
    end else begin
      d[31:0] = RET_32;
    end
    fetch_expect(addr, d, '1, 1'b1, bp_pkg::CF_RET, model_pop());
  endtask

  // --------------------
  // directed tests
  // --------------------

  task automatic test_call_return();
    call_jal(rand_addr(), 1);
    send_ret(rand_addr(), 1'b0);
  endtask

  task automatic test_nested_calls();
    call_cjal(rand_addr(), 0);
    call_jal(rand_addr(), 2);
    call_cjal(rand_addr(), 3);
    for (int i = 0; i < 3; i++) begin
      send_ret(rand_addr(), i[0]);
    end
  endtask

  task automatic test_straddle();
    logic [DATA_W-1:0] d;
    logic [20:0]       imm;
    logic [31:0]       inst;
    bp_pkg::vaddr_t    addr;
    bp_pkg::vaddr_t    pc;
    imm = rand_j_imm();
    // upper half alone then decodes as quadrant 0 with no control flow
    imm[17:16] = 2'b00;
    inst = enc_jal(5'd1, imm);
    addr = rand_addr();
    d = nop_block();
    d[DATA_W-16 +: 16] = inst[15:0];
    fetch_expect(addr, d, '1, 1'b0, bp_pkg::CF_NONE, '0);
    d = nop_block();
    d[15:0] = inst[31:16];
    pc = addr + bp_pkg::vaddr_t'(FETCH_BYTES - 2);
    model_push(pc + 4);
    fetch_expect(addr + FETCH_BYTES, d, '1, 1'b1, bp_pkg::CF_CALL, pc + sext_j(imm));
    // same halves, but the second block jumps elsewhere
    addr = rand_addr();
    d = nop_block();
    d[DATA_W-16 +: 16] = inst[15:0];
    fetch_expect(addr, d, '1, 1'b0, bp_pkg::CF_NONE, '0);
    d = nop_block();
    d[15:0] = inst[31:16];
    fetch_expect(addr + 4 * FETCH_BYTES, d, '1, 1'b0, bp_pkg::CF_NONE, '0);
    send_ret(rand_addr(), 1'b1);
  endtask

  task automatic test_jump_and_be();
    logic [DATA_W-1:0]      d;
    logic [FETCH_BYTES-1:0] be;
    call_cjal(rand_addr(), 1);
    // c.j ahead of a jal call
    d = nop_block();
    d[15:0]  = enc_cj(3'b101, rand_c_imm());
    d[16 +: 32] = enc_jal(5'd1, rand_j_imm());
    fetch_expect(rand_addr(), d, '1, 1'b0, bp_pkg::CF_NONE, '0);
    // call in a masked slot
    d = nop_block();
    d[31:0] = enc_jal(5'd1, rand_j_imm());
    be    = '1;
    be[0] = 1'b0;
    fetch_expect(rand_addr(), d, be, 1'b0, bp_pkg::CF_NONE, '0);
    send_ret(rand_addr(), 1'b0);
  endtask

  task automatic test_flush();
    int k;
    // fill every entry so that a wrong index reads another address
    for (int i = 0; i < RAS_DEPTH; i++) begin
      call_jal(rand_addr(), 0);
    end
    // flush target always differs from the current index
    k = (model_idx + 1 + int'($urandom % (RAS_DEPTH - 1))) % RAS_DEPTH;
    apply('0, make_upd(1'b0, 1'b1, 1'b0, k, '0));
    check_pred(1'b0, bp_pkg::CF_NONE, '0);
    model_idx = k;
    send_ret(rand_addr(), 1'b1);
  endtask

  task automatic test_repair();
    int             j;
    bp_pkg::vaddr_t r1;
    bp_pkg::vaddr_t r2;
    j  = int'($urandom % RAS_DEPTH);
    r1 = rand_addr() + 4;
    r2 = rand_addr() + 6;
    apply('0, make_upd(1'b1, 1'b0, 1'b1, j, r1));
    check_pred(1'b0, bp_pkg::CF_NONE, '0);
    model_ras[j] = r1;
    // recovery is on now, so this one must not land
    apply('0, make_upd(1'b1, 1'b0, 1'b1, j, r2));
    check_pred(1'b0, bp_pkg::CF_NONE, '0);
    apply('0, make_upd(1'b0, 1'b1, 1'b0, (j + 1) % RAS_DEPTH, '0));
    check_pred(1'b0, bp_pkg::CF_NONE, '0);
    model_idx = (j + 1) % RAS_DEPTH;
    send_ret(rand_addr(), 1'b0);
  endtask

  // --------------------
  // run control
  // --------------------

  initial begin
    void'($urandom(SEED));
    for (int i = 0; i < RAS_DEPTH; i++) begin
      model_ras[i] = '0;
    end
    model_idx = 0;
    reset_n <= 1'b0;
    fetch   <= '0;
    br_upd  <= '0;
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;
    test_call_return();
    test_nested_calls();
    test_straddle();
    test_jump_and_be();
    test_flush();
    test_repair();
    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * 50 * CLK_PERIOD);
    $display("watchdog: tests did not finish within %0d cycles", NUM_TESTS * 50);
    $display("** FAIL **");
    $finish;
  end

endmodule
